/* Bender.yml */
package:
  name: fabric

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ocp_pkg.sv
      - verilog/fabric_pkg.sv
      - verilog/fabric_port_decode.sv
      - verilog/fabric2_mswitch.sv
      - verilog/fabric_sarbiter.sv
      - verilog/fabric_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_slave_model.sv
      - testbench/tb_fabric.sv

/* list.f */
+incdir+verilog
verilog/ocp_pkg.sv
verilog/fabric_pkg.sv
verilog/fabric_port_decode.sv
verilog/fabric2_mswitch.sv
verilog/fabric_sarbiter.sv
verilog/fabric_top.sv
testbench/tb_slave_model.sv
testbench/tb_fabric.sv

/* testbench/tb_fabric.sv */
`include "fabric_params.svh"

`default_nettype none

module tb_fabric;

	localparam int RESET_CYCLES = 16;
	// commands issued by all tests together.
	localparam int NUM_CMDS = 49;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * NUM_CMDS;
	localparam fabric_pkg::master_e SIDE_I = fabric_pkg::MST_I;
	localparam fabric_pkg::master_e SIDE_D = fabric_pkg::MST_D;
	localparam ocp_pkg::ocp_cmd_e CMD_WR = ocp_pkg::WR;
	localparam ocp_pkg::ocp_cmd_e CMD_RD = ocp_pkg::RD;

	logic clk = 1'b0;
	logic rst = 1'b1;
	int cycle_cnt = 0;

	logic [`ADDR_WIDTH-1:0] im_addr;
	ocp_pkg::ocp_cmd_e im_cmd;
	logic [`DATA_WIDTH-1:0] im_data;
	logic [`BEN_WIDTH-1:0] im_ben;
	logic im_acc;
	logic [`DATA_WIDTH-1:0] im_sdata;
	ocp_pkg::ocp_resp_e im_sresp;
	logic [`ADDR_WIDTH-1:0] dm_addr;
	ocp_pkg::ocp_cmd_e dm_cmd;
	logic [`DATA_WIDTH-1:0] dm_data;
	logic [`BEN_WIDTH-1:0] dm_ben;
	logic dm_acc;
	logic [`DATA_WIDTH-1:0] dm_sdata;
	ocp_pkg::ocp_resp_e dm_sresp;

	// slave links with one entry per port.
	logic [`ADDR_WIDTH-1:0] s_maddr [5];
	ocp_pkg::ocp_cmd_e s_mcmd [5];
	logic [`DATA_WIDTH-1:0] s_mdata [5];
	logic [`BEN_WIDTH-1:0] s_mben [5];
	logic s_acc [5];
	logic [`DATA_WIDTH-1:0] s_sdata [5];
	ocp_pkg::ocp_resp_e s_sresp [5];

	fabric_top dut_i (
		.i_clk(clk), .i_rst(rst),
		.i_i_MAddr(im_addr), .i_i_MCmd(im_cmd), .i_i_MData(im_data), .i_i_MByteEn(im_ben),
		.o_i_SCmdAccept(im_acc), .o_i_SData(im_sdata), .o_i_SResp(im_sresp),
		.i_d_MAddr(dm_addr), .i_d_MCmd(dm_cmd), .i_d_MData(dm_data), .i_d_MByteEn(dm_ben),
		.o_d_SCmdAccept(dm_acc), .o_d_SData(dm_sdata), .o_d_SResp(dm_sresp),
		.o_s0_MAddr(s_maddr[0]), .o_s0_MCmd(s_mcmd[0]), .o_s0_MData(s_mdata[0]),
		.o_s0_MByteEn(s_mben[0]), .i_s0_SCmdAccept(s_acc[0]),
		.i_s0_SData(s_sdata[0]), .i_s0_SResp(s_sresp[0]),
		.o_s1_MAddr(s_maddr[1]), .o_s1_MCmd(s_mcmd[1]), .o_s1_MData(s_mdata[1]),
		.o_s1_MByteEn(s_mben[1]), .i_s1_SCmdAccept(s_acc[1]),
		.i_s1_SData(s_sdata[1]), .i_s1_SResp(s_sresp[1]),
		.o_s2_MAddr(s_maddr[2]), .o_s2_MCmd(s_mcmd[2]), .o_s2_MData(s_mdata[2]),
		.o_s2_MByteEn(s_mben[2]), .i_s2_SCmdAccept(s_acc[2]),
		.i_s2_SData(s_sdata[2]), .i_s2_SResp(s_sresp[2]),
		.o_s3_MAddr(s_maddr[3]), .o_s3_MCmd(s_mcmd[3]), .o_s3_MData(s_mdata[3]),
		.o_s3_MByteEn(s_mben[3]), .i_s3_SCmdAccept(s_acc[3]),
		.i_s3_SData(s_sdata[3]), .i_s3_SResp(s_sresp[3]),
		.o_s4_MAddr(s_maddr[4]), .o_s4_MCmd(s_mcmd[4]), .o_s4_MData(s_mdata[4]),
		.o_s4_MByteEn(s_mben[4]), .i_s4_SCmdAccept(s_acc[4]),
		.i_s4_SData(s_sdata[4]), .i_s4_SResp(s_sresp[4])
	);

	tb_slave_model #(.IDX(0)) slv0_i (
		.i_clk(clk), .i_rst(rst), .i_MAddr(s_maddr[0]), .i_MCmd(s_mcmd[0]),
		.i_MData(s_mdata[0]), .i_MByteEn(s_mben[0]), .o_SCmdAccept(s_acc[0]),
		.o_SData(s_sdata[0]), .o_SResp(s_sresp[0])
	);
	tb_slave_model #(.IDX(1)) slv1_i (
		.i_clk(clk), .i_rst(rst), .i_MAddr(s_maddr[1]), .i_MCmd(s_mcmd[1]),
		.i_MData(s_mdata[1]), .i_MByteEn(s_mben[1]), .o_SCmdAccept(s_acc[1]),
		.o_SData(s_sdata[1]), .o_SResp(s_sresp[1])
	);
	tb_slave_model #(.IDX(2)) slv2_i (
		.i_clk(clk), .i_rst(rst), .i_MAddr(s_maddr[2]), .i_MCmd(s_mcmd[2]),
		.i_MData(s_mdata[2]), .i_MByteEn(s_mben[2]), .o_SCmdAccept(s_acc[2]),
		.o_SData(s_sdata[2]), .o_SResp(s_sresp[2])
	);
	tb_slave_model #(.IDX(3)) slv3_i (
		.i_clk(clk), .i_rst(rst), .i_MAddr(s_maddr[3]), .i_MCmd(s_mcmd[3]),
		.i_MData(s_mdata[3]), .i_MByteEn(s_mben[3]), .o_SCmdAccept(s_acc[3]),
		.o_SData(s_sdata[3]), .o_SResp(s_sresp[3])
	);
	tb_slave_model #(.IDX(4)) slv4_i (
		.i_clk(clk), .i_rst(rst), .i_MAddr(s_maddr[4]), .i_MCmd(s_mcmd[4]),
		.i_MData(s_mdata[4]), .i_MByteEn(s_mben[4]), .o_SCmdAccept(s_acc[4]),
		.o_SData(s_sdata[4]), .o_SResp(s_sresp[4])
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("error: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("mismatch at time %0t: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [`DATA_WIDTH-1:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] ben);
		logic [`DATA_WIDTH-1:0] res;
		res = old_w;
		for (int b = 0; b < `BEN_WIDTH; b++) begin
			if (ben[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] slave_word(input int port, input int idx);
		case (port)
		1: return slv1_i.mem[idx];
		2: return slv2_i.mem[idx];
		3: return slv3_i.mem[idx];
		4: return slv4_i.mem[idx];
		default: return slv0_i.mem[idx];
		endcase
	endfunction

	task automatic drive_master(input fabric_pkg::master_e side, input ocp_pkg::ocp_cmd_e cmd,
		input logic [31:0] addr, input logic [31:0] data, input logic [3:0] ben);
		if (side == SIDE_I) begin
			im_cmd = cmd;
			im_addr = addr;
			im_data = data;
			im_ben = ben;
		end else begin
			dm_cmd = cmd;
			dm_addr = addr;
			dm_data = data;
			dm_ben = ben;
		end
	endtask

	task automatic read_master(input fabric_pkg::master_e side, output logic acc,
		output ocp_pkg::ocp_resp_e resp, output logic [31:0] data);
		if (side == SIDE_I) begin
			acc = im_acc;
			resp = im_sresp;
			data = im_sdata;
		end else begin
			acc = dm_acc;
			resp = dm_sresp;
			data = dm_sdata;
		end
	endtask

	// one OCP command is held until accepted and its response is collected.
	task automatic ocp_transfer(input fabric_pkg::master_e side, input ocp_pkg::ocp_cmd_e cmd,
		input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] ben,
		output logic [31:0] rdata, output int acc_cycle);
		logic acc;
		ocp_pkg::ocp_resp_e resp;
		logic [`DATA_WIDTH-1:0] sdata;
		@(negedge clk);
		drive_master(side, cmd, addr, wdata, ben);
		acc = 1'b0;
		while (!acc) begin
			@(posedge clk);
			read_master(side, acc, resp, sdata);
		end
		acc_cycle = cycle_cnt;
		@(negedge clk);
		// address stays put so the route holds until the response.
		drive_master(side, ocp_pkg::IDLE, addr, '0, '0);
		resp = ocp_pkg::NULL;
		while (resp == ocp_pkg::NULL) begin
			@(posedge clk);
			read_master(side, acc, resp, sdata);
		end
		check_value(resp, ocp_pkg::DVA, "response code");
		check_value(cycle_cnt, acc_cycle + 1, "response one cycle after accept");
		rdata = sdata;
	endtask

	task automatic check_reset_outputs();
		@(posedge clk);
		for (int n = 0; n < 5; n++) begin
			check_value(s_mcmd[n], ocp_pkg::IDLE, "slave MCmd idle after reset");
		end
		check_value(im_acc, 1'b0, "I accept low after reset");
		check_value(im_sresp, ocp_pkg::NULL, "I response NULL after reset");
		check_value(dm_acc, 1'b0, "D accept low after reset");
		check_value(dm_sresp, ocp_pkg::NULL, "D response NULL after reset");
	endtask

	task automatic check_grant_order(input int prev_d, input int acc_i, input int acc_d);
		check_value(acc_i > prev_d, 1'b1, "I granted after the previous D grant");
		check_value(acc_d > acc_i, 1'b1, "D granted after I");
	endtask

	// both masters hit slave 3 in the same cycle and I goes first after reset.
	task automatic contend_same_slave();
		logic [`DATA_WIDTH-1:0] wd_i;
		logic [`DATA_WIDTH-1:0] wd_d;
		logic [`DATA_WIDTH-1:0] rd_i;
		logic [`DATA_WIDTH-1:0] rd_d;
		int acc_i;
		int acc_d;
		int prev_d;
		prev_d = -1;
		for (int r = 0; r < 2; r++) begin
			wd_i = 32'hA1A1_0000 + r;
			wd_d = 32'hD2D2_0000 + r;
			fork
				ocp_transfer(SIDE_I, CMD_WR, 32'h3000_0004, wd_i, 4'hF, rd_i, acc_i);
				ocp_transfer(SIDE_D, CMD_WR, 32'h3000_0008, wd_d, 4'hF, rd_d, acc_d);
			join
			check_grant_order(prev_d, acc_i, acc_d);
			prev_d = acc_d;
			fork
				ocp_transfer(SIDE_I, CMD_RD, 32'h3000_0004, '0, 4'hF, rd_i, acc_i);
				ocp_transfer(SIDE_D, CMD_RD, 32'h3000_0008, '0, 4'hF, rd_d, acc_d);
			join
			check_grant_order(prev_d, acc_i, acc_d);
			prev_d = acc_d;
			check_value(rd_i, wd_i, "contended read via I");
			check_value(rd_d, wd_d, "contended read via D");
		end
		// a lone I grant hands the next tie to D.
		ocp_transfer(SIDE_I, CMD_RD, 32'h3000_0004, '0, 4'hF, rd_i, acc_i);
		check_value(rd_i, wd_i, "lone read via I");
		fork
			ocp_transfer(SIDE_I, CMD_RD, 32'h3000_0004, '0, 4'hF, rd_i, acc_i);
			ocp_transfer(SIDE_D, CMD_RD, 32'h3000_0008, '0, 4'hF, rd_d, acc_d);
		join
		check_value(acc_i > acc_d, 1'b1, "D granted first after an I grant");
		check_value(rd_i, wd_i, "contended read via I after D");
		check_value(rd_d, wd_d, "contended read via D first");
	endtask

	task automatic route_all_windows();
		logic [`ADDR_WIDTH-1:0] addrs [5];
		int ports [5];
		fabric_pkg::master_e side;
		logic [`DATA_WIDTH-1:0] wd;
		logic [`DATA_WIDTH-1:0] rd;
		int acc;
		addrs = '{32'h1000_0008, 32'h2000_0008, 32'h3000_0008, 32'h4000_0008, 32'h9000_0008};
		// the unmapped address belongs to the default slave.
		ports = '{1, 2, 3, 4, 0};
		for (int k = 0; k < 5; k++) begin
			for (int m = 0; m < 2; m++) begin
				side = fabric_pkg::master_e'(m);
				wd = 32'h7E00_0000 | (k << 8) | m;
				ocp_transfer(side, CMD_WR, addrs[k], wd, 4'hF, rd, acc);
				check_value(slave_word(ports[k], 2), wd, "word landed on decoded slave");
				ocp_transfer(side, CMD_RD, addrs[k], '0, 4'hF, rd, acc);
				check_value(rd, wd, "read back through window");
			end
		end
	endtask

	task automatic partial_write_check(input fabric_pkg::master_e side,
		input logic [31:0] addr, input logic [31:0] old_w, input logic [31:0] new_w,
		input logic [3:0] ben);
		logic [`DATA_WIDTH-1:0] rd;
		int acc;
		ocp_transfer(side, CMD_WR, addr, old_w, 4'hF, rd, acc);
		ocp_transfer(side, CMD_WR, addr, new_w, ben, rd, acc);
		ocp_transfer(side, CMD_RD, addr, '0, 4'hF, rd, acc);
		check_value(rd, merge_bytes(old_w, new_w, ben), "partial write merge");
	endtask

	task automatic write_partial_words();
		partial_write_check(SIDE_I, 32'h2000_0030, 32'hDEAD_BEEF, 32'h1234_5678, 4'b0101);
		partial_write_check(SIDE_D, 32'h0000_0014, 32'hCAFE_F00D, 32'hA5A5_A5A5, 4'b1000);
	endtask

	// I on slave 1 and D on slave 4 run side by side.
	task automatic run_parallel_slaves();
		logic [`ADDR_WIDTH-1:0] a_i;
		logic [`ADDR_WIDTH-1:0] a_d;
		logic [`DATA_WIDTH-1:0] wd_i;
		logic [`DATA_WIDTH-1:0] wd_d;
		logic [`DATA_WIDTH-1:0] rd_i;
		logic [`DATA_WIDTH-1:0] rd_d;
		int acc_i;
		int acc_d;
		for (int r = 0; r < 3; r++) begin
			a_i = 32'h1000_0040 + 4 * r;
			a_d = 32'h4000_0040 + 4 * r;
			wd_i = 32'h1111_0000 + r;
			wd_d = 32'h4444_0000 + r;
			fork
				ocp_transfer(SIDE_I, CMD_WR, a_i, wd_i, 4'hF, rd_i, acc_i);
				ocp_transfer(SIDE_D, CMD_WR, a_d, wd_d, 4'hF, rd_d, acc_d);
			join
			fork
				ocp_transfer(SIDE_I, CMD_RD, a_i, '0, 4'hF, rd_i, acc_i);
				ocp_transfer(SIDE_D, CMD_RD, a_d, '0, 4'hF, rd_d, acc_d);
			join
			check_value(rd_i, wd_i, "parallel read via I");
			check_value(rd_d, wd_d, "parallel read via D");
		end
	endtask

	initial begin
		drive_master(SIDE_I, ocp_pkg::IDLE, '0, '0, '0);
		drive_master(SIDE_D, ocp_pkg::IDLE, '0, '0, '0);
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		check_reset_outputs();
		contend_same_slave();
		route_all_windows();
		write_partial_words();
		run_parallel_slaves();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tb_slave_model.sv */
`include "fabric_params.svh"

`default_nettype none

module tb_slave_model #(
	parameter int IDX = 0,
	parameter int SEED = 94
)
(
	input wire i_clk,
	input wire i_rst,
	input wire [`ADDR_WIDTH-1:0] i_MAddr,
	input wire ocp_pkg::ocp_cmd_e i_MCmd,
	input wire [`DATA_WIDTH-1:0] i_MData,
	input wire [`BEN_WIDTH-1:0] i_MByteEn,
	output logic o_SCmdAccept,
	output logic [`DATA_WIDTH-1:0] o_SData,
	output ocp_pkg::ocp_resp_e o_SResp
);

	logic [`DATA_WIDTH-1:0] mem [16];
	logic [`DATA_WIDTH-1:0] rdata_q;
	logic live_q;
	logic pend_q;
	int wait_q;
	int delay_q;
	integer seed;

	initial begin
		// each slave offsets the common seed by its index.
		seed = SEED + IDX;
		for (int k = 0; k < 16; k++) begin
			mem[k] = 32'h5A00_0000 + (IDX << 16) + k;
		end
		rdata_q = '0;
		live_q = 1'b0;
		pend_q = 1'b0;
		wait_q = 0;
		delay_q = 0;
		o_SCmdAccept = 1'b0;
		o_SData = '0;
		o_SResp = ocp_pkg::NULL;
	end

	// command side, sampled on the rising edge.
	always @(posedge i_clk) begin
		if (i_rst) begin
			live_q <= 1'b0;
			pend_q <= 1'b0;
			wait_q <= 0;
			delay_q <= 0;
		end else begin
			live_q <= 1'b1;
			if (pend_q) begin
				// response is shown for one cycle only.
				pend_q <= 1'b0;
			end else if ((i_MCmd != ocp_pkg::IDLE) && o_SCmdAccept) begin
				pend_q <= 1'b1;
				wait_q <= 0;
				delay_q <= $unsigned($random(seed)) % 3;
				rdata_q <= mem[i_MAddr[5:2]];
				if (i_MCmd == ocp_pkg::WR) begin
					for (int b = 0; b < `BEN_WIDTH; b++) begin
						if (i_MByteEn[b]) begin
							mem[i_MAddr[5:2]][8*b +: 8] <= i_MData[8*b +: 8];
						end
					end
				end
			end else if (i_MCmd != ocp_pkg::IDLE) begin
				wait_q <= wait_q + 1;
			end
		end
	end

	// accept and response change on the falling edge.
	always @(negedge i_clk) begin
		o_SCmdAccept <= live_q && !pend_q && (wait_q >= delay_q);
		if (pend_q) begin
			o_SResp <= ocp_pkg::DVA;
			o_SData <= rdata_q;
		end else begin
			o_SResp <= ocp_pkg::NULL;
			o_SData <= '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/fabric2_mswitch.sv */
`include "fabric_params.svh"

`default_nettype none

module fabric2_mswitch #(
	parameter PORTNO_WIDTH = 3
)
(
	input wire [PORTNO_WIDTH-1:0] i_portno,
	// master side.
	input wire [`ADDR_WIDTH-1:0] i_ID_MAddr,
	input wire ocp_pkg::ocp_cmd_e i_ID_MCmd,
	input wire [`DATA_WIDTH-1:0] i_ID_MData,
	input wire [`BEN_WIDTH-1:0] i_ID_MByteEn,
	output logic o_ID_SCmdAccept,
	output logic [`DATA_WIDTH-1:0] o_ID_SData,
	output ocp_pkg::ocp_resp_e o_ID_SResp,
	// link 0, the default slave.
	output logic [`ADDR_WIDTH-1:0] o_P0_MAddr,
	output ocp_pkg::ocp_cmd_e o_P0_MCmd,
	output logic [`DATA_WIDTH-1:0] o_P0_MData,
	output logic [`BEN_WIDTH-1:0] o_P0_MByteEn,
	input wire i_P0_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_P0_SData,
	input wire ocp_pkg::ocp_resp_e i_P0_SResp,
	// link 1.
	output logic [`ADDR_WIDTH-1:0] o_P1_MAddr,
	output ocp_pkg::ocp_cmd_e o_P1_MCmd,
	output logic [`DATA_WIDTH-1:0] o_P1_MData,
	output logic [`BEN_WIDTH-1:0] o_P1_MByteEn,
	input wire i_P1_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_P1_SData,
	input wire ocp_pkg::ocp_resp_e i_P1_SResp,
	// link 2.
	output logic [`ADDR_WIDTH-1:0] o_P2_MAddr,
	output ocp_pkg::ocp_cmd_e o_P2_MCmd,
	output logic [`DATA_WIDTH-1:0] o_P2_MData,
	output logic [`BEN_WIDTH-1:0] o_P2_MByteEn,
	input wire i_P2_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_P2_SData,
	input wire ocp_pkg::ocp_resp_e i_P2_SResp,
	// link 3.
	output logic [`ADDR_WIDTH-1:0] o_P3_MAddr,
	output ocp_pkg::ocp_cmd_e o_P3_MCmd,
	output logic [`DATA_WIDTH-1:0] o_P3_MData,
	output logic [`BEN_WIDTH-1:0] o_P3_MByteEn,
	input wire i_P3_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_P3_SData,
	input wire ocp_pkg::ocp_resp_e i_P3_SResp,
	// link 4.
	output logic [`ADDR_WIDTH-1:0] o_P4_MAddr,
	output ocp_pkg::ocp_cmd_e o_P4_MCmd,
	output logic [`DATA_WIDTH-1:0] o_P4_MData,
	output logic [`BEN_WIDTH-1:0] o_P4_MByteEn,
	input wire i_P4_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_P4_SData,
	input wire ocp_pkg::ocp_resp_e i_P4_SResp
);

	logic [4:0] sel;

	// one-hot link select, port numbers above 4 go to link 0.
	assign sel[1] = (i_portno == PORTNO_WIDTH'(1));
	assign sel[2] = (i_portno == PORTNO_WIDTH'(2));
	assign sel[3] = (i_portno == PORTNO_WIDTH'(3));
	assign sel[4] = (i_portno == PORTNO_WIDTH'(4));
	assign sel[0] = ~|sel[4:1];

	// unselected links stay idle with every field at zero.
	assign o_P0_MAddr = sel[0] ? i_ID_MAddr : '0;
	assign o_P0_MCmd = sel[0] ? i_ID_MCmd : ocp_pkg::IDLE;
	assign o_P0_MData = sel[0] ? i_ID_MData : '0;
	assign o_P0_MByteEn = sel[0] ? i_ID_MByteEn : '0;
	assign o_P1_MAddr = sel[1] ? i_ID_MAddr : '0;
	assign o_P1_MCmd = sel[1] ? i_ID_MCmd : ocp_pkg::IDLE;
	assign o_P1_MData = sel[1] ? i_ID_MData : '0;
	assign o_P1_MByteEn = sel[1] ? i_ID_MByteEn : '0;
	assign o_P2_MAddr = sel[2] ? i_ID_MAddr : '0;
	assign o_P2_MCmd = sel[2] ? i_ID_MCmd : ocp_pkg::IDLE;
	assign o_P2_MData = sel[2] ? i_ID_MData : '0;
	assign o_P2_MByteEn = sel[2] ? i_ID_MByteEn : '0;
	assign o_P3_MAddr = sel[3] ? i_ID_MAddr : '0;
	assign o_P3_MCmd = sel[3] ? i_ID_MCmd : ocp_pkg::IDLE;
	assign o_P3_MData = sel[3] ? i_ID_MData : '0;
	assign o_P3_MByteEn = sel[3] ? i_ID_MByteEn : '0;
	assign o_P4_MAddr = sel[4] ? i_ID_MAddr : '0;
	assign o_P4_MCmd = sel[4] ? i_ID_MCmd : ocp_pkg::IDLE;
	assign o_P4_MData = sel[4] ? i_ID_MData : '0;
	assign o_P4_MByteEn = sel[4] ? i_ID_MByteEn : '0;

	// accept and response come back from the selected link only.
	always_comb begin
		case (i_portno)
		PORTNO_WIDTH'(1): begin
			o_ID_SCmdAccept = i_P1_SCmdAccept;
			o_ID_SData = i_P1_SData;
			o_ID_SResp = i_P1_SResp;
		end
		PORTNO_WIDTH'(2): begin
			o_ID_SCmdAccept = i_P2_SCmdAccept;
			o_ID_SData = i_P2_SData;
			o_ID_SResp = i_P2_SResp;
		end
		PORTNO_WIDTH'(3): begin
			o_ID_SCmdAccept = i_P3_SCmdAccept;
			o_ID_SData = i_P3_SData;
			o_ID_SResp = i_P3_SResp;
		end
		PORTNO_WIDTH'(4): begin
			o_ID_SCmdAccept = i_P4_SCmdAccept;
			o_ID_SData = i_P4_SData;
			o_ID_SResp = i_P4_SResp;
		end
		default: begin
			o_ID_SCmdAccept = i_P0_SCmdAccept;
			o_ID_SData = i_P0_SData;
			o_ID_SResp = i_P0_SResp;
		end
		endcase
	end

	// a response never overtakes the accept of a pending command.
	always_comb begin
		assert final (!((i_ID_MCmd != ocp_pkg::IDLE) && !o_ID_SCmdAccept &&
			(o_ID_SResp != ocp_pkg::NULL)))
		else $error("mswitch: response seen while command still waits for accept");
	end

endmodule

`default_nettype wire

/* verilog/fabric_params.svh */
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// OCP link widths.
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define BEN_WIDTH 4

// a window is picked by the top address nibble.
`define PORT_MASK 32'hF000_0000
`define PORT1_BASE 32'h1000_0000
`define PORT2_BASE 32'h2000_0000
`define PORT3_BASE 32'h3000_0000
`define PORT4_BASE 32'h4000_0000

`endif

/* verilog/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

	// per-slave arbiter states.
	typedef enum logic [1:0] {
		ARB_IDLE   = 2'd0,
		ARB_WAIT_I = 2'd1,
		ARB_WAIT_D = 2'd2
	} arb_state_e;

	// owner of a slave port.
	typedef enum logic {
		MST_I = 1'b0,
		MST_D = 1'b1
	} master_e;

endpackage

`default_nettype wire

/* verilog/fabric_port_decode.sv */
`include "fabric_params.svh"

`default_nettype none

module fabric_port_decode #(
	parameter PORTNO_WIDTH = 3
)
(
	input wire [`ADDR_WIDTH-1:0] i_addr,
	output logic [PORTNO_WIDTH-1:0] o_portno
);

	logic [`ADDR_WIDTH-1:0] window;

	// only the window bits take part in the compare.
	assign window = i_addr & `PORT_MASK;

	always_comb begin
		if (window == `PORT1_BASE) begin
			o_portno = PORTNO_WIDTH'(1);
		end else if (window == `PORT2_BASE) begin
			o_portno = PORTNO_WIDTH'(2);
		end else if (window == `PORT3_BASE) begin
			o_portno = PORTNO_WIDTH'(3);
		end else if (window == `PORT4_BASE) begin
			o_portno = PORTNO_WIDTH'(4);
		end else begin
			// unmapped addresses fall to the default slave.
			o_portno = PORTNO_WIDTH'(0);
		end
	end

endmodule

`default_nettype wire

/* verilog/fabric_sarbiter.sv */
`include "fabric_params.svh"

`default_nettype none

module fabric_sarbiter (
	input wire i_clk,
	input wire i_rst,
	// I-side master.
	input wire [`ADDR_WIDTH-1:0] i_i_MAddr,
	input wire ocp_pkg::ocp_cmd_e i_i_MCmd,
	input wire [`DATA_WIDTH-1:0] i_i_MData,
	input wire [`BEN_WIDTH-1:0] i_i_MByteEn,
	output logic o_i_SCmdAccept,
	output logic [`DATA_WIDTH-1:0] o_i_SData,
	output ocp_pkg::ocp_resp_e o_i_SResp,
	// D-side master.
	input wire [`ADDR_WIDTH-1:0] i_d_MAddr,
	input wire ocp_pkg::ocp_cmd_e i_d_MCmd,
	input wire [`DATA_WIDTH-1:0] i_d_MData,
	input wire [`BEN_WIDTH-1:0] i_d_MByteEn,
	output logic o_d_SCmdAccept,
	output logic [`DATA_WIDTH-1:0] o_d_SData,
	output ocp_pkg::ocp_resp_e o_d_SResp,
	// slave port.
	output logic [`ADDR_WIDTH-1:0] o_s_MAddr,
	output ocp_pkg::ocp_cmd_e o_s_MCmd,
	output logic [`DATA_WIDTH-1:0] o_s_MData,
	output logic [`BEN_WIDTH-1:0] o_s_MByteEn,
	input wire i_s_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_s_SData,
	input wire ocp_pkg::ocp_resp_e i_s_SResp
);

	fabric_pkg::arb_state_e state_q;
	fabric_pkg::master_e last_q;
	fabric_pkg::master_e grant;
	logic req_i;
	logic req_d;
	logic fwd_i;
	logic fwd_d;

	assign req_i = (i_i_MCmd != ocp_pkg::IDLE);
	assign req_d = (i_d_MCmd != ocp_pkg::IDLE);

	// on a tie the master that lost last time wins.
	assign grant = (req_d && (!req_i || (last_q == fabric_pkg::MST_I))) ?
		fabric_pkg::MST_D : fabric_pkg::MST_I;

	// commands pass only while no response is outstanding.
	assign fwd_i = (state_q == fabric_pkg::ARB_IDLE) && req_i && (grant == fabric_pkg::MST_I);
	assign fwd_d = (state_q == fabric_pkg::ARB_IDLE) && req_d && (grant == fabric_pkg::MST_D);

	assign o_s_MAddr = fwd_i ? i_i_MAddr : fwd_d ? i_d_MAddr : '0;
	assign o_s_MCmd = fwd_i ? i_i_MCmd : fwd_d ? i_d_MCmd : ocp_pkg::IDLE;
	assign o_s_MData = fwd_i ? i_i_MData : fwd_d ? i_d_MData : '0;
	assign o_s_MByteEn = fwd_i ? i_i_MByteEn : fwd_d ? i_d_MByteEn : '0;

	// the loser sees no accept and keeps holding its command.
	assign o_i_SCmdAccept = fwd_i & i_s_SCmdAccept;
	assign o_d_SCmdAccept = fwd_d & i_s_SCmdAccept;

	// response goes back to the owner only.
	assign o_i_SData = (state_q == fabric_pkg::ARB_WAIT_I) ? i_s_SData : '0;
	assign o_i_SResp = (state_q == fabric_pkg::ARB_WAIT_I) ? i_s_SResp : ocp_pkg::NULL;
	assign o_d_SData = (state_q == fabric_pkg::ARB_WAIT_D) ? i_s_SData : '0;
	assign o_d_SResp = (state_q == fabric_pkg::ARB_WAIT_D) ? i_s_SResp : ocp_pkg::NULL;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= fabric_pkg::ARB_IDLE;
			// marks D as last winner so I goes first.
			last_q <= fabric_pkg::MST_D;
		end else begin
			case (state_q)
			fabric_pkg::ARB_IDLE: begin
				if (i_s_SCmdAccept && (fwd_i || fwd_d)) begin
					state_q <= fwd_i ? fabric_pkg::ARB_WAIT_I : fabric_pkg::ARB_WAIT_D;
					last_q <= grant;
				end
			end
			default: begin
				if (i_s_SResp != ocp_pkg::NULL) begin
					state_q <= fabric_pkg::ARB_IDLE;
				end
			end
			endcase
		end
	end

	// slave may only respond to a command it has accepted.
	assert property (@(posedge i_clk) disable iff (i_rst)
		(state_q == fabric_pkg::ARB_IDLE) |-> (i_s_SResp == ocp_pkg::NULL))
	else $error("sarbiter: response with no command outstanding");

	// an accepted master owns the slave on the next cycle.
	assert property (@(posedge i_clk) disable iff (i_rst)
		o_i_SCmdAccept |=> (state_q == fabric_pkg::ARB_WAIT_I))
	else $error("sarbiter: accepted I command did not take the slave");

	assert property (@(posedge i_clk) disable iff (i_rst)
		o_d_SCmdAccept |=> (state_q == fabric_pkg::ARB_WAIT_D))
	else $error("sarbiter: accepted D command did not take the slave");

endmodule

`default_nettype wire

/* verilog/fabric_top.sv */
`include "fabric_params.svh"

`default_nettype none

module fabric_top (
	input wire i_clk,
	input wire i_rst,
	// instruction fetch master.
	input wire [`ADDR_WIDTH-1:0] i_i_MAddr,
	input wire ocp_pkg::ocp_cmd_e i_i_MCmd,
	input wire [`DATA_WIDTH-1:0] i_i_MData,
	input wire [`BEN_WIDTH-1:0] i_i_MByteEn,
	output logic o_i_SCmdAccept,
	output logic [`DATA_WIDTH-1:0] o_i_SData,
	output ocp_pkg::ocp_resp_e o_i_SResp,
	// data master.
	input wire [`ADDR_WIDTH-1:0] i_d_MAddr,
	input wire ocp_pkg::ocp_cmd_e i_d_MCmd,
	input wire [`DATA_WIDTH-1:0] i_d_MData,
	input wire [`BEN_WIDTH-1:0] i_d_MByteEn,
	output logic o_d_SCmdAccept,
	output logic [`DATA_WIDTH-1:0] o_d_SData,
	output ocp_pkg::ocp_resp_e o_d_SResp,
	// slave 0, the default slave.
	output logic [`ADDR_WIDTH-1:0] o_s0_MAddr,
	output ocp_pkg::ocp_cmd_e o_s0_MCmd,
	output logic [`DATA_WIDTH-1:0] o_s0_MData,
	output logic [`BEN_WIDTH-1:0] o_s0_MByteEn,
	input wire i_s0_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_s0_SData,
	input wire ocp_pkg::ocp_resp_e i_s0_SResp,
	// slave 1.
	output logic [`ADDR_WIDTH-1:0] o_s1_MAddr,
	output ocp_pkg::ocp_cmd_e o_s1_MCmd,
	output logic [`DATA_WIDTH-1:0] o_s1_MData,
	output logic [`BEN_WIDTH-1:0] o_s1_MByteEn,
	input wire i_s1_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_s1_SData,
	input wire ocp_pkg::ocp_resp_e i_s1_SResp,
	// slave 2.
	output logic [`ADDR_WIDTH-1:0] o_s2_MAddr,
	output ocp_pkg::ocp_cmd_e o_s2_MCmd,
	output logic [`DATA_WIDTH-1:0] o_s2_MData,
	output logic [`BEN_WIDTH-1:0] o_s2_MByteEn,
	input wire i_s2_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_s2_SData,
	input wire ocp_pkg::ocp_resp_e i_s2_SResp,
	// slave 3.
	output logic [`ADDR_WIDTH-1:0] o_s3_MAddr,
	output ocp_pkg::ocp_cmd_e o_s3_MCmd,
	output logic [`DATA_WIDTH-1:0] o_s3_MData,
	output logic [`BEN_WIDTH-1:0] o_s3_MByteEn,
	input wire i_s3_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_s3_SData,
	input wire ocp_pkg::ocp_resp_e i_s3_SResp,
	// slave 4.
	output logic [`ADDR_WIDTH-1:0] o_s4_MAddr,
	output ocp_pkg::ocp_cmd_e o_s4_MCmd,
	output logic [`DATA_WIDTH-1:0] o_s4_MData,
	output logic [`BEN_WIDTH-1:0] o_s4_MByteEn,
	input wire i_s4_SCmdAccept,
	input wire [`DATA_WIDTH-1:0] i_s4_SData,
	input wire ocp_pkg::ocp_resp_e i_s4_SResp
);

	localparam PORTNO_W = 3;

	logic [PORTNO_W-1:0] i_portno;
	logic [PORTNO_W-1:0] d_portno;

	// links from the I switch to the arbiters.
	logic [`ADDR_WIDTH-1:0] il_maddr [5];
	ocp_pkg::ocp_cmd_e il_mcmd [5];
	logic [`DATA_WIDTH-1:0] il_mdata [5];
	logic [`BEN_WIDTH-1:0] il_mben [5];
	logic il_acc [5];
	logic [`DATA_WIDTH-1:0] il_sdata [5];
	ocp_pkg::ocp_resp_e il_sresp [5];

	// links from the D switch to the arbiters.
	logic [`ADDR_WIDTH-1:0] dl_maddr [5];
	ocp_pkg::ocp_cmd_e dl_mcmd [5];
	logic [`DATA_WIDTH-1:0] dl_mdata [5];
	logic [`BEN_WIDTH-1:0] dl_mben [5];
	logic dl_acc [5];
	logic [`DATA_WIDTH-1:0] dl_sdata [5];
	ocp_pkg::ocp_resp_e dl_sresp [5];

	fabric_port_decode #(.PORTNO_WIDTH(PORTNO_W)) idec_i (
		.i_addr(i_i_MAddr), .o_portno(i_portno)
	);

	fabric_port_decode #(.PORTNO_WIDTH(PORTNO_W)) ddec_i (
		.i_addr(i_d_MAddr), .o_portno(d_portno)
	);

	fabric2_mswitch #(.PORTNO_WIDTH(PORTNO_W)) isw_i (
		.i_portno(i_portno),
		.i_ID_MAddr(i_i_MAddr), .i_ID_MCmd(i_i_MCmd), .i_ID_MData(i_i_MData),
		.i_ID_MByteEn(i_i_MByteEn), .o_ID_SCmdAccept(o_i_SCmdAccept),
		.o_ID_SData(o_i_SData), .o_ID_SResp(o_i_SResp),
		.o_P0_MAddr(il_maddr[0]), .o_P0_MCmd(il_mcmd[0]), .o_P0_MData(il_mdata[0]),
		.o_P0_MByteEn(il_mben[0]), .i_P0_SCmdAccept(il_acc[0]),
		.i_P0_SData(il_sdata[0]), .i_P0_SResp(il_sresp[0]),
		.o_P1_MAddr(il_maddr[1]), .o_P1_MCmd(il_mcmd[1]), .o_P1_MData(il_mdata[1]),
		.o_P1_MByteEn(il_mben[1]), .i_P1_SCmdAccept(il_acc[1]),
		.i_P1_SData(il_sdata[1]), .i_P1_SResp(il_sresp[1]),
		.o_P2_MAddr(il_maddr[2]), .o_P2_MCmd(il_mcmd[2]), .o_P2_MData(il_mdata[2]),
		.o_P2_MByteEn(il_mben[2]), .i_P2_SCmdAccept(il_acc[2]),
		.i_P2_SData(il_sdata[2]), .i_P2_SResp(il_sresp[2]),
		.o_P3_MAddr(il_maddr[3]), .o_P3_MCmd(il_mcmd[3]), .o_P3_MData(il_mdata[3]),
		.o_P3_MByteEn(il_mben[3]), .i_P3_SCmdAccept(il_acc[3]),
		.i_P3_SData(il_sdata[3]), .i_P3_SResp(il_sresp[3]),
		.o_P4_MAddr(il_maddr[4]), .o_P4_MCmd(il_mcmd[4]), .o_P4_MData(il_mdata[4]),
		.o_P4_MByteEn(il_mben[4]), .i_P4_SCmdAccept(il_acc[4]),
		.i_P4_SData(il_sdata[4]), .i_P4_SResp(il_sresp[4])
	);

	fabric2_mswitch #(.PORTNO_WIDTH(PORTNO_W)) dsw_i (
		.i_portno(d_portno),
		.i_ID_MAddr(i_d_MAddr), .i_ID_MCmd(i_d_MCmd), .i_ID_MData(i_d_MData),
		.i_ID_MByteEn(i_d_MByteEn), .o_ID_SCmdAccept(o_d_SCmdAccept),
		.o_ID_SData(o_d_SData), .o_ID_SResp(o_d_SResp),
		.o_P0_MAddr(dl_maddr[0]), .o_P0_MCmd(dl_mcmd[0]), .o_P0_MData(dl_mdata[0]),
		.o_P0_MByteEn(dl_mben[0]), .i_P0_SCmdAccept(dl_acc[0]),
		.i_P0_SData(dl_sdata[0]), .i_P0_SResp(dl_sresp[0]),
		.o_P1_MAddr(dl_maddr[1]), .o_P1_MCmd(dl_mcmd[1]), .o_P1_MData(dl_mdata[1]),
		.o_P1_MByteEn(dl_mben[1]), .i_P1_SCmdAccept(dl_acc[1]),
		.i_P1_SData(dl_sdata[1]), .i_P1_SResp(dl_sresp[1]),
		.o_P2_MAddr(dl_maddr[2]), .o_P2_MCmd(dl_mcmd[2]), .o_P2_MData(dl_mdata[2]),
		.o_P2_MByteEn(dl_mben[2]), .i_P2_SCmdAccept(dl_acc[2]),
		.i_P2_SData(dl_sdata[2]), .i_P2_SResp(dl_sresp[2]),
		.o_P3_MAddr(dl_maddr[3]), .o_P3_MCmd(dl_mcmd[3]), .o_P3_MData(dl_mdata[3]),
		.o_P3_MByteEn(dl_mben[3]), .i_P3_SCmdAccept(dl_acc[3]),
		.i_P3_SData(dl_sdata[3]), .i_P3_SResp(dl_sresp[3]),
		.o_P4_MAddr(dl_maddr[4]), .o_P4_MCmd(dl_mcmd[4]), .o_P4_MData(dl_mdata[4]),
		.o_P4_MByteEn(dl_mben[4]), .i_P4_SCmdAccept(dl_acc[4]),
		.i_P4_SData(dl_sdata[4]), .i_P4_SResp(dl_sresp[4])
	);

	fabric_sarbiter arb0_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_i_MAddr(il_maddr[0]), .i_i_MCmd(il_mcmd[0]), .i_i_MData(il_mdata[0]),
		.i_i_MByteEn(il_mben[0]), .o_i_SCmdAccept(il_acc[0]),
		.o_i_SData(il_sdata[0]), .o_i_SResp(il_sresp[0]),
		.i_d_MAddr(dl_maddr[0]), .i_d_MCmd(dl_mcmd[0]), .i_d_MData(dl_mdata[0]),
		.i_d_MByteEn(dl_mben[0]), .o_d_SCmdAccept(dl_acc[0]),
		.o_d_SData(dl_sdata[0]), .o_d_SResp(dl_sresp[0]),
		.o_s_MAddr(o_s0_MAddr), .o_s_MCmd(o_s0_MCmd), .o_s_MData(o_s0_MData),
		.o_s_MByteEn(o_s0_MByteEn), .i_s_SCmdAccept(i_s0_SCmdAccept),
		.i_s_SData(i_s0_SData), .i_s_SResp(i_s0_SResp)
	);

	fabric_sarbiter arb1_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_i_MAddr(il_maddr[1]), .i_i_MCmd(il_mcmd[1]), .i_i_MData(il_mdata[1]),
		.i_i_MByteEn(il_mben[1]), .o_i_SCmdAccept(il_acc[1]),
		.o_i_SData(il_sdata[1]), .o_i_SResp(il_sresp[1]),
		.i_d_MAddr(dl_maddr[1]), .i_d_MCmd(dl_mcmd[1]), .i_d_MData(dl_mdata[1]),
		.i_d_MByteEn(dl_mben[1]), .o_d_SCmdAccept(dl_acc[1]),
		.o_d_SData(dl_sdata[1]), .o_d_SResp(dl_sresp[1]),
		.o_s_MAddr(o_s1_MAddr), .o_s_MCmd(o_s1_MCmd), .o_s_MData(o_s1_MData),
		.o_s_MByteEn(o_s1_MByteEn), .i_s_SCmdAccept(i_s1_SCmdAccept),
		.i_s_SData(i_s1_SData), .i_s_SResp(i_s1_SResp)
	);

	fabric_sarbiter arb2_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_i_MAddr(il_maddr[2]), .i_i_MCmd(il_mcmd[2]), .i_i_MData(il_mdata[2]),
		.i_i_MByteEn(il_mben[2]), .o_i_SCmdAccept(il_acc[2]),
		.o_i_SData(il_sdata[2]), .o_i_SResp(il_sresp[2]),
		.i_d_MAddr(dl_maddr[2]), .i_d_MCmd(dl_mcmd[2]), .i_d_MData(dl_mdata[2]),
		.i_d_MByteEn(dl_mben[2]), .o_d_SCmdAccept(dl_acc[2]),
		.o_d_SData(dl_sdata[2]), .o_d_SResp(dl_sresp[2]),
		.o_s_MAddr(o_s2_MAddr), .o_s_MCmd(o_s2_MCmd), .o_s_MData(o_s2_MData),
		.o_s_MByteEn(o_s2_MByteEn), .i_s_SCmdAccept(i_s2_SCmdAccept),
		.i_s_SData(i_s2_SData), .i_s_SResp(i_s2_SResp)
	);

	fabric_sarbiter arb3_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_i_MAddr(il_maddr[3]), .i_i_MCmd(il_mcmd[3]), .i_i_MData(il_mdata[3]),
		.i_i_MByteEn(il_mben[3]), .o_i_SCmdAccept(il_acc[3]),
		.o_i_SData(il_sdata[3]), .o_i_SResp(il_sresp[3]),
		.i_d_MAddr(dl_maddr[3]), .i_d_MCmd(dl_mcmd[3]), .i_d_MData(dl_mdata[3]),
		.i_d_MByteEn(dl_mben[3]), .o_d_SCmdAccept(dl_acc[3]),
		.o_d_SData(dl_sdata[3]), .o_d_SResp(dl_sresp[3]),
		.o_s_MAddr(o_s3_MAddr), .o_s_MCmd(o_s3_MCmd), .o_s_MData(o_s3_MData),
		.o_s_MByteEn(o_s3_MByteEn), .i_s_SCmdAccept(i_s3_SCmdAccept),
		.i_s_SData(i_s3_SData), .i_s_SResp(i_s3_SResp)
	);

	fabric_sarbiter arb4_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_i_MAddr(il_maddr[4]), .i_i_MCmd(il_mcmd[4]), .i_i_MData(il_mdata[4]),
		.i_i_MByteEn(il_mben[4]), .o_i_SCmdAccept(il_acc[4]),
		.o_i_SData(il_sdata[4]), .o_i_SResp(il_sresp[4]),
		.i_d_MAddr(dl_maddr[4]), .i_d_MCmd(dl_mcmd[4]), .i_d_MData(dl_mdata[4]),
		.i_d_MByteEn(dl_mben[4]), .o_d_SCmdAccept(dl_acc[4]),
		.o_d_SData(dl_sdata[4]), .o_d_SResp(dl_sresp[4]),
		.o_s_MAddr(o_s4_MAddr), .o_s_MCmd(o_s4_MCmd), .o_s_MData(o_s4_MData),
		.o_s_MByteEn(o_s4_MByteEn), .i_s_SCmdAccept(i_s4_SCmdAccept),
		.i_s_SData(i_s4_SData), .i_s_SResp(i_s4_SResp)
	);

endmodule

`default_nettype wire

/* verilog/ocp_pkg.sv */
`default_nettype none

package ocp_pkg;

	// master command codes.
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		WR   = 3'd1,
		RD   = 3'd2
	} ocp_cmd_e;

	// slave response codes, 2'd2 is unused.
	typedef enum logic [1:0] {
		NULL = 2'd0,
		DVA  = 2'd1,
		ERR  = 2'd3
	} ocp_resp_e;

endpackage

`default_nettype wire
